/* hdl/mtag_pkg.sv */
// Tag-check widths, pointer field positions, vector typedefs and request opcode
`default_nettype none

package mtag_pkg;

    // Field widths
    localparam int PTR_WIDTH  = 32;             // Full pointer
    localparam int TAG_WIDTH  = 4;              // Key in pointer, tag in memory
    localparam int GRAN_WIDTH = 8;              // Granule index

    // Pointer field positions
    localparam int GRAN_LSB = 4;                // 16-byte granules
    localparam int KEY_LSB  = 28;               // Key sits in the top nibble

    // Tag memory geometry
    localparam int GRAN_COUNT = 2 ** GRAN_WIDTH; // 256 granule tags

    // Match-all key, never flags a violation
    localparam logic [TAG_WIDTH-1:0] MATCH_ALL_KEY = '0;

    // All tags return to zero on reset
    localparam bit CLEAR_TAGS_ON_RESET = 1'b1;

    // Vector types with a meaning
    typedef logic [PTR_WIDTH-1:0]  ptr_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [GRAN_WIDTH-1:0] gran_t;

    // Request kind
    typedef enum logic {
        OP_CHECK = 1'b0,                        // Compare key with stored tag
        OP_SET   = 1'b1                         // Store a new tag
    } mtag_op_e;

endpackage : mtag_pkg

`default_nettype wire

/* hdl/mtag_stage_if.sv */
// Request bundle passed between tag-check pipeline stages, with sender and receiver views
`timescale 1ns/1ps
`default_nettype none

interface mtag_stage_if;

    import mtag_pkg::*;

    logic     valid;    // One-cycle request strobe
    mtag_op_e op;       // Check or set
    tag_t     key;      // Pointer key, or new tag for a set
    gran_t    gran;     // Granule index
    tag_t     mem_tag;  // Stored tag, valid after the memory stage

    // Upstream stage
    modport src (
        output valid,
        output op,
        output key,
        output gran,
        output mem_tag
    );

    // Downstream stage
    modport dst (
        input valid,
        input op,
        input key,
        input gran,
        input mem_tag
    );

endinterface : mtag_stage_if

`default_nettype wire

/* hdl/mtag_decode_stage.sv */
// Decode stage registering a tag request and splitting its pointer into key and granule
`timescale 1ns/1ps
`default_nettype none

module mtag_decode_stage (
    input  wire logic               clk_i,
    input  wire logic               RESET_MEM,     // Synchronous, active high
    input  wire logic               req_valid_i,   // Request strobe
    input  wire mtag_pkg::mtag_op_e req_op_i,
    input  wire mtag_pkg::ptr_t     req_ptr_i,
    input  wire mtag_pkg::tag_t     req_tag_i,     // New tag, sets only
    mtag_stage_if.src               out_o
);

    import mtag_pkg::*;

    tag_t  ptr_key;   // Key field of the pointer
    gran_t ptr_gran;  // Granule field of the pointer
    tag_t  sel_key;   // Key or new tag, by opcode

    // Bits 27:12 and 3:0 are dropped here
    assign ptr_key  = req_ptr_i[KEY_LSB +: TAG_WIDTH];
    assign ptr_gran = req_ptr_i[GRAN_LSB +: GRAN_WIDTH];

    // A set carries its new tag in the key slot
    assign sel_key = (req_op_i == OP_SET) ? req_tag_i : ptr_key;

    // Strobe register
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= req_valid_i;
        end
    end

    // Payload, qualified by valid downstream
    always_ff @(posedge clk_i) begin
        out_o.op   <= req_op_i;
        out_o.key  <= sel_key;
        out_o.gran <= ptr_gran;
    end

    // Filled in by the memory stage
    assign out_o.mem_tag = '0;

endmodule : mtag_decode_stage

`default_nettype wire

/* hdl/mtag_mem.sv */
// Tag memory stage with one read and one write port, write bypass and reset clear
`timescale 1ns/1ps
`default_nettype none

module mtag_mem (
    input  wire logic clk_i,
    input  wire logic RESET_MEM,  // Synchronous, active high; clears tags
    mtag_stage_if.dst in_i,       // From decode stage
    mtag_stage_if.src out_o       // To check stage
);

    import mtag_pkg::*;

    tag_t  tag_mem [GRAN_COUNT];  // One tag per granule

    logic  set_en;                // Valid set this cycle
    logic  chk_en;                // Valid check this cycle
    logic  wr_hit;                // Check hits the previous write
    tag_t  rd_tag;                // Read data after bypass

    // Last write, for read-after-write on the following cycle
    logic  last_wr_valid_q;
    gran_t last_wr_gran_q;
    tag_t  last_wr_tag_q;

    assign set_en = in_i.valid && (in_i.op == OP_SET);
    assign chk_en = in_i.valid && (in_i.op == OP_CHECK);

    // Forward the tag written one cycle earlier
    assign wr_hit = chk_en && last_wr_valid_q && (last_wr_gran_q == in_i.gran);
    assign rd_tag = wr_hit ? last_wr_tag_q : tag_mem[in_i.gran];

    // Control state and tag array
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            out_o.valid     <= 1'b0;
            last_wr_valid_q <= 1'b0;
            if (CLEAR_TAGS_ON_RESET) begin
                for (int idx = 0; idx < GRAN_COUNT; idx++) begin
                    tag_mem[idx] <= '0;
                end
            end
        end else begin
            out_o.valid     <= in_i.valid;
            last_wr_valid_q <= set_en;
            if (set_en) begin
                tag_mem[in_i.gran] <= in_i.key;  // New tag rides in key
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        out_o.op   <= in_i.op;
        out_o.key  <= in_i.key;
        out_o.gran <= in_i.gran;
        // A set forwards its own tag
        out_o.mem_tag <= set_en ? in_i.key : rd_tag;
        last_wr_gran_q <= in_i.gran;
        last_wr_tag_q  <= in_i.key;
    end

endmodule : mtag_mem

`default_nettype wire

/* hdl/mtag_check_stage.sv */
// Check stage comparing pointer key with stored tag and producing the result strobe
`timescale 1ns/1ps
`default_nettype none

module mtag_check_stage (
    input  wire logic clk_i,
    input  wire logic RESET_MEM,        // Synchronous, active high
    mtag_stage_if.dst in_i,             // From memory stage
    output logic      res_valid_o,      // One strobe per check
    output logic      res_violation_o   // Key and tag disagree
);

    import mtag_pkg::*;

    logic is_check;   // Valid check request
    logic key_wild;   // Match-all key
    logic mismatch;   // Key differs from stored tag

    // Sets stop here without a result
    assign is_check = in_i.valid && (in_i.op == OP_CHECK);

    assign key_wild = (in_i.key == MATCH_ALL_KEY);
    assign mismatch = (in_i.key != in_i.mem_tag);

    // Result registers
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            res_valid_o     <= 1'b0;
            res_violation_o <= 1'b0;
        end else begin
            res_valid_o     <= is_check;
            // Only flagged together with a strobe
            res_violation_o <= is_check && !key_wild && mismatch;
        end
    end

endmodule : mtag_check_stage

`default_nettype wire

/* hdl/mtag_unit.sv */
// Tag-check unit top level with decode, tag memory and check stages
`timescale 1ns/1ps
`default_nettype none

module mtag_unit (
    input  wire logic               clk_i,
    input  wire logic               RESET_MEM,       // Synchronous, active high
    // Request side
    input  wire logic               req_valid_i,     // One-cycle strobe
    input  wire mtag_pkg::mtag_op_e req_op_i,        // Check or set
    input  wire mtag_pkg::ptr_t     req_ptr_i,       // Key in 31:28, granule in 11:4
    input  wire mtag_pkg::tag_t     req_tag_i,       // New tag for sets
    // Result side, three cycles after a check
    output logic                    res_valid_o,
    output logic                    res_violation_o
);

    // Decode to memory
    mtag_stage_if dec_if ();

    // Memory to check
    mtag_stage_if lkp_if ();

    // Stage 1, split pointer
    mtag_decode_stage u_decode (
        .clk_i       (clk_i),
        .RESET_MEM   (RESET_MEM),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_ptr_i   (req_ptr_i),
        .req_tag_i   (req_tag_i),
        .out_o       (dec_if.src)
    );

    // Stage 2, tag lookup and update
    mtag_mem u_mem (
        .clk_i     (clk_i),
        .RESET_MEM (RESET_MEM),
        .in_i      (dec_if.dst),
        .out_o     (lkp_if.src)
    );

    // Stage 3, compare and report
    mtag_check_stage u_check (
        .clk_i           (clk_i),
        .RESET_MEM       (RESET_MEM),
        .in_i            (lkp_if.dst),
        .res_valid_o     (res_valid_o),
        .res_violation_o (res_violation_o)
    );

endmodule : mtag_unit

`default_nettype wire

/* testbench/mtag_unit_asserts.sv */
// Concurrent port assertions for the tag-check unit and their bind to the top level
`timescale 1ns/1ps
`default_nettype none

module mtag_unit_asserts (
    input wire logic               clk_i,
    input wire logic               RESET_MEM,
    input wire logic               req_valid_i,
    input wire mtag_pkg::mtag_op_e req_op_i,
    input wire logic               res_valid_o,
    input wire logic               res_violation_o
);

    import mtag_pkg::*;

    logic chk_accept;  // Check taken by the decode stage this edge

    assign chk_accept = req_valid_i && (req_op_i == OP_CHECK) && !RESET_MEM;

    // Quiet during reset and the cycle after
    a_reset_quiet : assert property (@(posedge clk_i)
        ($past(RESET_MEM, 1) || $past(RESET_MEM, 2)) |-> (!res_valid_o && !res_violation_o))
        else $error("Result outputs active during or right after reset");

    // Flag rides on the strobe
    a_flag_with_strobe : assert property (@(posedge clk_i)
        res_violation_o |-> res_valid_o)
        else $error("res_violation_o high without res_valid_o");

    // Three cycles from request to result, unless reset cut it off
    a_latency : assert property (@(posedge clk_i)
        ($past(chk_accept, 3) && !$past(RESET_MEM, 2) && !$past(RESET_MEM, 1)) |-> res_valid_o)
        else $error("res_valid_o missing three cycles after a check request");

    a_no_stray : assert property (@(posedge clk_i)
        res_valid_o |-> $past(chk_accept, 3))
        else $error("res_valid_o without a check request three cycles earlier");

endmodule : mtag_unit_asserts

bind mtag_unit mtag_unit_asserts u_asserts (
    .clk_i           (clk_i),
    .RESET_MEM       (RESET_MEM),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .res_valid_o     (res_valid_o),
    .res_violation_o (res_violation_o)
);

`default_nettype wire

/* testbench/mtag_unit_tb.sv */
// Tag-check unit testbench with clock, reset, LFSR stimulus, tag model, result compare and watchdog
`timescale 1ns/1ps
`default_nettype none

module mtag_unit_tb;

    import mtag_pkg::*;

    localparam int          CLK_PERIOD     = 4;        // ns
    localparam int          RESET_CYCLES   = 4;
    localparam int          DIR_COUNT      = 16;       // Rounds per directed phase
    localparam int          RAND_REQS      = 400;
    localparam int          PRE_RESET_REQS = 20;       // Traffic cut by the second reset
    localparam logic [15:0] LFSR_SEED      = 16'd33686;
    localparam logic [15:0] LFSR_TAPS      = 16'hB400; // x^16+x^14+x^13+x^11+1
    localparam int          TOTAL_REQS     = 4 * GRAN_COUNT + 13 * DIR_COUNT
                                             + RAND_REQS + PRE_RESET_REQS;

    logic     clk_i = 1'b0;
    logic     RESET_MEM;
    logic     req_valid_i;
    mtag_op_e req_op_i;
    ptr_t     req_ptr_i;
    tag_t     req_tag_i;
    logic     res_valid_o;
    logic     res_violation_o;

    tag_t        model_tags [GRAN_COUNT];  // Reference tag memory
    logic        exp_q [$];                // Expected violation flags, in order
    int          n_expected = 0;
    int          n_seen     = 0;
    logic [15:0] lfsr_state;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    mtag_unit UUT (
        .clk_i           (clk_i),
        .RESET_MEM       (RESET_MEM),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_ptr_i       (req_ptr_i),
        .req_tag_i       (req_tag_i),
        .res_valid_o     (res_valid_o),
        .res_violation_o (res_violation_o)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        lfsr_step = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Violation unless key is match-all or equals the stored tag
    function automatic logic expect_violation(input tag_t key, input tag_t stored);
        expect_violation = (key != MATCH_ALL_KEY) && (key != stored);
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Stopping at first failure");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns",
                     name, actual, expected, $time);
            abort_run();
        end
    endtask

    // Drive one request for one cycle and update the model at issue time
    task automatic send_request(input mtag_op_e op, input tag_t key, input gran_t gran,
                                input logic [15:0] alias_bits, input logic [3:0] offset,
                                input tag_t new_tag);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_ptr_i   <= {key, alias_bits, gran, offset};
        req_tag_i   <= new_tag;
        if (op == OP_SET) begin
            model_tags[gran] = new_tag;
        end else begin
            exp_q.push_back(expect_violation(key, model_tags[gran]));
            n_expected++;
        end
        @(posedge clk_i);
    endtask

    task automatic send_idle();
        req_valid_i <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic send_random();
        logic [31:0] bits;
        logic [31:0] op_bit;
        take_bits(1, op_bit);
        take_bits(32, bits);
        // Sixteen hot granules so sets and checks meet often
        send_request(op_bit[0] ? OP_SET : OP_CHECK, bits[3:0], {4'hA, bits[7:4]},
                     bits[23:8], bits[27:24], bits[31:28]);
    endtask

    // Checks in flight are lost and tags go back to zero
    task automatic apply_reset();
        RESET_MEM   <= 1'b1;
        req_valid_i <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        RESET_MEM <= 1'b0;
        n_expected -= exp_q.size();
        exp_q.delete();
        for (int g = 0; g < GRAN_COUNT; g++) begin
            model_tags[g] = '0;
        end
    endtask

    // Each granule checked with one random key and one forced nonzero key
    task automatic sweep_fresh_tags();
        logic [31:0] bits;
        for (int g = 0; g < GRAN_COUNT; g++) begin
            take_bits(20, bits);
            send_request(OP_CHECK, bits[3:0], gran_t'(g), bits[19:4], 4'h0, '0);
            send_request(OP_CHECK, tag_t'((g % 15) + 1), gran_t'(g), bits[19:4], bits[3:0], '0);
        end
    endtask

    // Results are stable at the falling edge
    always @(negedge clk_i) begin : compare_results
        logic exp_v;
        if (res_valid_o === 1'b1) begin
            n_seen++;
            if (exp_q.size() == 0) begin
                $display("Result strobe arrived with no check outstanding at %0t ns", $time);
                abort_run();
            end else begin
                exp_v = exp_q.pop_front();
                compare_value("res_violation_o", 32'(res_violation_o), 32'(exp_v));
            end
        end
    end

    initial begin : watchdog
        #((TOTAL_REQS + 100) * CLK_PERIOD);
        $display("Watchdog expired, the run hung before all results came back");
        abort_run();
    end

    initial begin : stimulus
        logic [31:0] bits;
        tag_t        new_tag;
        tag_t        other;
        gran_t       gran;
        RESET_MEM   = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = OP_CHECK;
        req_ptr_i   = '0;
        req_tag_i   = '0;
        lfsr_state  = LFSR_SEED;
        apply_reset();
        sweep_fresh_tags();                   // All tags zero
        for (int n = 0; n < 3 * DIR_COUNT; n++) begin
            take_bits(32, bits);
            gran    = bits[7:0];
            new_tag = bits[11:8];
            other   = (new_tag == 4'hF) ? 4'h1 : new_tag + 4'h1;  // Nonzero and not the tag
            if (n < DIR_COUNT) begin
                // Set then later checks from memory
                send_request(OP_SET, bits[3:0], gran, 16'h0, 4'h0, new_tag);
                send_idle();
                send_request(OP_CHECK, new_tag, gran, 16'h0, 4'h8, '0);
                send_request(OP_CHECK, other, gran, 16'h0, 4'h8, '0);
                send_request(OP_CHECK, MATCH_ALL_KEY, gran, 16'h0, 4'h8, '0);
            end else if (n < 2 * DIR_COUNT) begin
                send_request(OP_SET, bits[3:0], gran, 16'h0, 4'h0, new_tag);
                send_request(OP_CHECK, new_tag, gran, 16'h0, 4'h0, '0);   // Bypass hit
                send_request(OP_CHECK, other, gran, 16'h0, 4'h0, '0);
                send_request(OP_SET, bits[3:0], gran ^ 8'h80, 16'h0, 4'h0, other);
                send_request(OP_CHECK, new_tag, gran, 16'h0, 4'h0, '0);   // Neighbour untouched
            end else begin
                // Aliasing through bits 27:12 and then through bits 3:0
                send_request(OP_SET, bits[3:0], gran, bits[27:12], 4'h0, new_tag);
                send_request(OP_CHECK, new_tag, gran, ~bits[27:12], 4'h0, '0);
                send_request(OP_CHECK, new_tag, gran, bits[27:12], bits[31:28] | 4'h1,
                             '0);                 // Nonzero offset, same granule
            end
        end
        for (int n = 0; n < RAND_REQS; n++) begin
            send_random();
        end
        for (int n = 0; n < PRE_RESET_REQS; n++) begin
            send_random();
        end
        apply_reset();                        // Mid-traffic reset
        sweep_fresh_tags();
        req_valid_i <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);          // Room for stray strobes
        if (n_seen != n_expected) begin
            $display("Saw %0d result strobes for %0d checks", n_seen, n_expected);
            abort_run();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule : mtag_unit_tb

`default_nettype wire

/* mtag.f */
hdl/mtag_pkg.sv
hdl/mtag_stage_if.sv
hdl/mtag_decode_stage.sv
hdl/mtag_mem.sv
hdl/mtag_check_stage.sv
hdl/mtag_unit.sv
testbench/mtag_unit_asserts.sv
testbench/mtag_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the tag-check unit testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    --top-module mtag_unit_tb \
    -f mtag.f \
    -o mtag_sim &&
./obj_dir/mtag_sim ||
{ echo "Simulation run returned a failing status"; exit 1; }
